// ==== filelist.f ====
source/dcache_pkg.sv
source/dcache_frame_array.sv
source/dcache_lookup.sv
source/dcache_ctrl.sv
source/dcache.sv
verif/dcache_ram_model.sv
verif/dcache_checker.sv
verif/dcache_tb.sv

// ==== source/dcache.sv ====
/*
 dcache top
 two-way write-back data cache, 8 sets of two-word blocks,
 frame array, lookup and control FSM tied to CPU and memory
 */

module dcache
   import dcache_pkg::*;
#(
   parameter word_t HIT_COUNT_ADDR = DEFAULT_HIT_COUNT_ADDR
) (
   input  logic  CLK,
   input  logic  nRST,
   // cpu side
   input  logic  dmem_ren,
   input  logic  dmem_wen,
   input  word_t dmem_addr,
   input  word_t dmem_store,
   input  logic  halt,
   output word_t dmem_load,
   output logic  dhit,
   output logic  flushed,
   // memory side
   output logic  mem_ren,
   output logic  mem_wen,
   output word_t mem_addr,
   output word_t mem_store,
   input  word_t mem_load,
   input  logic  mem_wait
);

   dcache_idx_t        rd_idx;
   dcache_idx_t        wr_idx;
   dcache_frame_t      wr_frame;
   dcache_way_frames_t frames;
   logic               wr_en;
   logic               wr_way;
   logic               hit;
   logic               hit_way;
   logic               victim_way;
   logic               touch;
   logic               touch_way;

   dcache_frame_array u_array (
      .CLK       (CLK),
      .nRST      (nRST),
      .rd_idx    (rd_idx),
      .wr_en     (wr_en),
      .wr_way    (wr_way),
      .wr_idx    (wr_idx),
      .wr_frame  (wr_frame),
      .rd_frames (frames)
   );

   // compares against the request address
   dcache_lookup u_lookup (
      .CLK        (CLK),
      .nRST       (nRST),
      .addr       (dmem_addr),
      .frames     (frames),
      .touch      (touch),
      .touch_way  (touch_way),
      .hit        (hit),
      .hit_way    (hit_way),
      .victim_way (victim_way)
   );

   dcache_ctrl #(
      .HIT_COUNT_ADDR (HIT_COUNT_ADDR)
   ) u_ctrl (
      .CLK        (CLK),
      .nRST       (nRST),
      .dmem_ren   (dmem_ren),
      .dmem_wen   (dmem_wen),
      .dmem_addr  (dmem_addr),
      .dmem_store (dmem_store),
      .halt       (halt),
      .mem_load   (mem_load),
      .mem_wait   (mem_wait),
      .frames     (frames),
      .hit        (hit),
      .hit_way    (hit_way),
      .victim_way (victim_way),
      .dmem_load  (dmem_load),
      .dhit       (dhit),
      .flushed    (flushed),
      .mem_ren    (mem_ren),
      .mem_wen    (mem_wen),
      .mem_addr   (mem_addr),
      .mem_store  (mem_store),
      .rd_idx     (rd_idx),
      .wr_en      (wr_en),
      .wr_way     (wr_way),
      .wr_idx     (wr_idx),
      .wr_frame   (wr_frame),
      .touch      (touch),
      .touch_way  (touch_way)
   );

endmodule

// ==== source/dcache_ctrl.sv ====
/*
 dcache control FSM
 hit service, writeback then fill on a miss,
 flush walk and hit-count store on halt
 */

module dcache_ctrl
   import dcache_pkg::*;
#(
   parameter word_t HIT_COUNT_ADDR = DEFAULT_HIT_COUNT_ADDR
) (
   input  logic               CLK,
   input  logic               nRST,
   input  logic               dmem_ren,
   input  logic               dmem_wen,
   input  word_t              dmem_addr,
   input  word_t              dmem_store,
   input  logic               halt,
   input  word_t              mem_load,
   input  logic               mem_wait,
   input  dcache_way_frames_t frames,
   input  logic               hit,
   input  logic               hit_way,
   input  logic               victim_way,
   output word_t              dmem_load,
   output logic               dhit,
   output logic               flushed,
   output logic               mem_ren,
   output logic               mem_wen,
   output word_t              mem_addr,
   output word_t              mem_store,
   output dcache_idx_t        rd_idx,
   output logic               wr_en,
   output logic               wr_way,
   output dcache_idx_t        wr_idx,
   output dcache_frame_t      wr_frame,
   output logic               touch,
   output logic               touch_way
);

   typedef enum logic [3:0] {
      IDLE, WB0, WB1, RD0, RD1, FILL,
      FLUSH, FLUSH_WB0, FLUSH_WB1, HIT_WR, DONE
   } state_t;

   state_t state_q, next_state;

   // flush pointer {way, set}, walks way 0 first
   logic [WAY_W+IDX_W-1:0] flush_ptr_q;
   logic                   flush_step;
   logic                   flush_last;
   logic                   flush_way;
   dcache_idx_t            flush_idx;

   word_t       hit_count_q;
   logic        count_hit;
   logic        miss_way_q;
   word_t [1:0] fill_q;

   logic              req;
   dcache_tag_t       tag;
   dcache_idx_t       idx;
   logic [BLK_W-1:0]  blk;
   dcache_frame_t     vic;
   dcache_frame_t     fl;

   assign req = dmem_ren || dmem_wen;
   assign tag = addr_tag(dmem_addr);
   assign idx = addr_idx(dmem_addr);
   assign blk = addr_blk(dmem_addr);

   assign flush_way  = flush_ptr_q[WAY_W+IDX_W-1];
   assign flush_idx  = flush_ptr_q[IDX_W-1:0];
   assign flush_last = &flush_ptr_q;

   // frame being evicted or flushed
   // rd_idx picks the set, these pick the way
   assign vic = frames[miss_way_q];
   assign fl  = frames[flush_way];

   // writes always land in the request's set
   assign wr_idx = idx;

   always_comb begin
      next_state = state_q;
      rd_idx     = idx;
      dhit       = 1'b0;
      dmem_load  = frames[hit_way].data[blk];
      flushed    = 1'b0;
      mem_ren    = 1'b0;
      mem_wen    = 1'b0;
      mem_addr   = '0;
      mem_store  = '0;
      wr_en      = 1'b0;
      wr_way     = hit_way;
      wr_frame   = frames[hit_way];
      touch      = 1'b0;
      touch_way  = hit_way;
      count_hit  = 1'b0;
      flush_step = 1'b0;

      unique case (state_q)
         IDLE: begin
            if (req && hit) begin
               // answered this cycle
               dhit      = 1'b1;
               touch     = 1'b1;
               count_hit = 1'b1;
               if (dmem_wen) begin
                  wr_en              = 1'b1;
                  wr_frame.dirty     = 1'b1;
                  wr_frame.data[blk] = dmem_store;
               end
            end
            else if (req) begin
               // dirty victim goes out before the fetch
               if (frames[victim_way].valid && frames[victim_way].dirty) begin
                  next_state = WB0;
               end
               else begin
                  next_state = RD0;
               end
            end
            else if (halt) begin
               next_state = FLUSH;
            end
         end
         WB0, WB1: begin
            mem_wen   = 1'b1;
            mem_addr  = blk_addr(vic.tag, idx, BLK_W'(state_q == WB1));
            mem_store = vic.data[state_q == WB1];
            if (!mem_wait) begin
               next_state = (state_q == WB0) ? WB1 : RD0;
            end
         end
         RD0, RD1: begin
            mem_ren  = 1'b1;
            mem_addr = blk_addr(tag, idx, BLK_W'(state_q == RD1));
            if (!mem_wait) begin
               next_state = (state_q == RD0) ? RD1 : FILL;
            end
         end
         FILL: begin
            // whole block in, store merged on a write miss
            dhit               = 1'b1;
            dmem_load          = fill_q[blk];
            wr_en              = 1'b1;
            wr_way             = miss_way_q;
            wr_frame.valid     = 1'b1;
            wr_frame.dirty     = dmem_wen;
            wr_frame.tag       = tag;
            wr_frame.data      = fill_q;
            if (dmem_wen) begin
               wr_frame.data[blk] = dmem_store;
            end
            touch      = 1'b1;
            touch_way  = miss_way_q;
            next_state = IDLE;
         end
         FLUSH: begin
            rd_idx = flush_idx;
            if (fl.valid && fl.dirty) begin
               next_state = FLUSH_WB0;
            end
            else begin
               flush_step = 1'b1;
            end
         end
         FLUSH_WB0, FLUSH_WB1: begin
            rd_idx    = flush_idx;
            mem_wen   = 1'b1;
            mem_addr  = blk_addr(fl.tag, flush_idx, BLK_W'(state_q == FLUSH_WB1));
            mem_store = fl.data[state_q == FLUSH_WB1];
            if (!mem_wait) begin
               if (state_q == FLUSH_WB0) begin
                  next_state = FLUSH_WB1;
               end
               else begin
                  flush_step = 1'b1;
               end
            end
         end
         HIT_WR: begin
            mem_wen   = 1'b1;
            mem_addr  = HIT_COUNT_ADDR;
            mem_store = hit_count_q;
            if (!mem_wait) begin
               next_state = DONE;
            end
         end
         DONE: begin
            // held until reset
            flushed = 1'b1;
         end
         default: begin
            next_state = IDLE;
         end
      endcase

      // move on to the next frame, or finish with the hit count
      if (flush_step) begin
         next_state = flush_last ? HIT_WR : FLUSH;
      end
   end

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         state_q     <= IDLE;
         flush_ptr_q <= '0;
         hit_count_q <= '0;
      end
      else begin
         state_q <= next_state;
         if (flush_step) begin
            flush_ptr_q <= flush_ptr_q + 1'b1;
         end
         if (count_hit) begin
            hit_count_q <= hit_count_q + 32'd1;
         end
      end
   end

   // victim way fixed while still idle
   // fetched words captured as each read completes
   always_ff @(posedge CLK) begin
      if (state_q == IDLE) begin
         miss_way_q <= victim_way;
      end
      if (state_q == RD0 && !mem_wait) begin
         fill_q[0] <= mem_load;
      end
      if (state_q == RD1 && !mem_wait) begin
         fill_q[1] <= mem_load;
      end
   end

endmodule

// ==== source/dcache_frame_array.sv ====
/*
 dcache frame storage
 valid, dirty, tag and two data words per way and set,
 combinational read of one set, one whole-frame write per cycle
 */

module dcache_frame_array
   import dcache_pkg::*;
(
   input  logic               CLK,
   input  logic               nRST,
   input  dcache_idx_t        rd_idx,
   input  logic               wr_en,
   input  logic               wr_way,
   input  dcache_idx_t        wr_idx,
   input  dcache_frame_t      wr_frame,
   output dcache_way_frames_t rd_frames
);

   // state bits per way, one bit per set
   logic [NUM_SETS-1:0] valid_q [NUM_WAYS];
   logic [NUM_SETS-1:0] dirty_q [NUM_WAYS];

   // tag and data payload
   dcache_tag_t         tag_q  [NUM_WAYS][NUM_SETS];
   logic [2*WORD_W-1:0] data_q [NUM_WAYS][NUM_SETS];

   // valid and dirty cleared on reset
   // so every frame starts out invalid
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         for (int w = 0; w < NUM_WAYS; w++) begin
            valid_q[w] <= '0;
            dirty_q[w] <= '0;
         end
      end
      else if (wr_en) begin
         valid_q[wr_way][wr_idx] <= wr_frame.valid;
         dirty_q[wr_way][wr_idx] <= wr_frame.dirty;
      end
   end

   // payload only changes on a write
   always_ff @(posedge CLK) begin
      if (wr_en) begin
         tag_q[wr_way][wr_idx]  <= wr_frame.tag;
         data_q[wr_way][wr_idx] <= wr_frame.data;
      end
   end

   // both ways of the indexed set
   // no bypass, a write shows up the cycle after
   always_comb begin
      for (int w = 0; w < NUM_WAYS; w++) begin
         rd_frames[w].valid = valid_q[w][rd_idx];
         rd_frames[w].dirty = dirty_q[w][rd_idx];
         rd_frames[w].tag   = tag_q[w][rd_idx];
         rd_frames[w].data  = data_q[w][rd_idx];
      end
   end

endmodule

// ==== source/dcache_lookup.sv ====
/*
 dcache lookup
 tag compare over both ways, victim choice and per-set LRU bits
 */

module dcache_lookup
   import dcache_pkg::*;
(
   input  logic               CLK,
   input  logic               nRST,
   input  word_t              addr,
   input  dcache_way_frames_t frames,
   input  logic               touch,
   input  logic               touch_way,
   output logic               hit,
   output logic               hit_way,
   output logic               victim_way
);

   dcache_tag_t         tag;
   dcache_idx_t         idx;
   logic [NUM_WAYS-1:0] way_match;

   // lru_q[set] names the least recently used way
   logic [NUM_SETS-1:0] lru_q;

   assign tag = addr_tag(addr);
   assign idx = addr_idx(addr);

   // a way matches only when valid with equal tag
   always_comb begin
      for (int w = 0; w < NUM_WAYS; w++) begin
         way_match[w] = frames[w].valid && (frames[w].tag == tag);
      end
   end

   assign hit = |way_match;

   // way 0 wins, although both ways never hold the same tag
   assign hit_way = way_match[1] && !way_match[0];

   // empty way first, way 0 before way 1
   // then fall back on lru
   always_comb begin
      if (!frames[0].valid) begin
         victim_way = 1'b0;
      end
      else if (!frames[1].valid) begin
         victim_way = 1'b1;
      end
      else begin
         victim_way = lru_q[idx];
      end
   end

   // touched way becomes mru
   // so the other way turns into lru
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         lru_q <= '0;
      end
      else if (touch) begin
         lru_q[idx] <= ~touch_way;
      end
   end

endmodule

// ==== source/dcache_pkg.sv ====
/*
 dcache shared definitions
 address fields, frame layout and the flush hit-count address
 */

package dcache_pkg;

   // address split {tag, index, block word, byte}
   localparam int WORD_W   = 32;
   localparam int TAG_W    = 26;
   localparam int IDX_W    = 3;
   localparam int BLK_W    = 1;
   localparam int BYTE_W   = 2;
   localparam int NUM_SETS = 8;
   localparam int WAY_W    = 1;
   localparam int NUM_WAYS = 2 ** WAY_W;

   typedef logic [WORD_W-1:0] word_t;
   typedef logic [TAG_W-1:0]  dcache_tag_t;
   typedef logic [IDX_W-1:0]  dcache_idx_t;

   // data[0] holds the word whose block bit is 0
   typedef struct packed {
      logic        valid;
      logic        dirty;
      dcache_tag_t tag;
      word_t [1:0] data;
   } dcache_frame_t;

   typedef dcache_frame_t [NUM_WAYS-1:0] dcache_way_frames_t;

   // hit count lands here after the flush walk
   localparam word_t DEFAULT_HIT_COUNT_ADDR = 32'h3100;

   function automatic dcache_tag_t addr_tag(input word_t a);
      return a[WORD_W-1 -: TAG_W];
   endfunction

   function automatic dcache_idx_t addr_idx(input word_t a);
      return a[BYTE_W+BLK_W +: IDX_W];
   endfunction

   function automatic logic [BLK_W-1:0] addr_blk(input word_t a);
      return a[BYTE_W +: BLK_W];
   endfunction

   // rebuild a word address from its fields
   function automatic word_t blk_addr(input dcache_tag_t t, input dcache_idx_t i,
                                      input logic [BLK_W-1:0] b);
      return {t, i, b, {BYTE_W{1'b0}}};
   endfunction

endpackage

// ==== verif/dcache_checker.sv ====
/*
 dcache checker
 concurrent assertions on the memory handshake, dhit and flushed
 */

module dcache_checker
   import dcache_pkg::*;
(
   input logic  CLK,
   input logic  nRST,
   input logic  dmem_ren,
   input logic  dmem_wen,
   input logic  dhit,
   input logic  flushed,
   input logic  mem_ren,
   input logic  mem_wen,
   input word_t mem_addr,
   input word_t mem_store,
   input logic  mem_wait
);

   // read back by the testbench at the end of the run
   int fail_count = 0;

   // one direction at a time
   a_one_dir: assert property (@(posedge CLK) disable iff (!nRST)
      !(mem_ren && mem_wen))
   else begin
      $error("mem_ren and mem_wen high together");
      fail_count++;
   end

   // a stalled transfer keeps address, data and direction
   a_hold: assert property (@(posedge CLK) disable iff (!nRST)
      (mem_ren || mem_wen) && mem_wait |=>
         $stable(mem_addr) && $stable(mem_store) && $stable({mem_ren, mem_wen}))
   else begin
      $error("memory request changed while mem_wait was high");
      fail_count++;
   end

   // sticky until reset
   a_flushed_sticky: assert property (@(posedge CLK) disable iff (!nRST)
      flushed |=> flushed)
   else begin
      $error("flushed fell");
      fail_count++;
   end

   a_no_stray_hit: assert property (@(posedge CLK) disable iff (!nRST)
      !(dmem_ren || dmem_wen) |-> !dhit)
   else begin
      $error("dhit high without a request");
      fail_count++;
   end

endmodule

bind dcache dcache_checker u_checker (
   .CLK       (CLK),
   .nRST      (nRST),
   .dmem_ren  (dmem_ren),
   .dmem_wen  (dmem_wen),
   .dhit      (dhit),
   .flushed   (flushed),
   .mem_ren   (mem_ren),
   .mem_wen   (mem_wen),
   .mem_addr  (mem_addr),
   .mem_store (mem_store),
   .mem_wait  (mem_wait)
);

// ==== verif/dcache_ram_model.sv ====
/*
 dcache memory model
 word memory behind the cache, 0 to 3 random wait cycles per transfer
 */

module dcache_ram_model
   import dcache_pkg::*;
#(
   parameter word_t PATTERN = 32'hA5A5_0000
) (
   input  logic  CLK,
   input  logic  nRST,
   input  logic  mem_ren,
   input  logic  mem_wen,
   input  word_t mem_addr,
   input  word_t mem_store,
   output word_t mem_load,
   output logic  mem_wait
);

   // 16 KB of words, covers the test range and the hit-count word
   localparam int DEPTH = 4096;

   word_t       mem [DEPTH];
   logic [1:0]  wait_cnt_q;
   logic [11:0] widx;
   logic        req;
   integer      seed = 22;

   assign widx     = mem_addr[13:2];
   assign req      = mem_ren || mem_wen;
   assign mem_load = mem[widx];
   assign mem_wait = req && (wait_cnt_q != 2'd0);

   // initial word is its own byte address xor the pattern
   initial begin
      for (int i = 0; i < DEPTH; i++) begin
         mem[i] = (word_t'(i) << 2) ^ PATTERN;
      end
   end

   // count down while busy
   // fresh draw when idle or when a transfer completes
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         wait_cnt_q <= '0;
      end
      else if (req && wait_cnt_q != 2'd0) begin
         wait_cnt_q <= wait_cnt_q - 2'd1;
      end
      else begin
         wait_cnt_q <= 2'($random(seed));
      end
   end

   // write lands on the completing edge
   always @(posedge CLK) begin
      if (mem_wen && !mem_wait) begin
         mem[widx] <= mem_store;
      end
   end

endmodule

// ==== verif/dcache_tb.sv ====
/*
 dcache testbench
 directed and random CPU accesses against a reference model,
 then a halt flush checked against the memory model
 */

module dcache_tb;
   import dcache_pkg::*;

   localparam word_t PATTERN       = 32'hA5A5_0000;
   localparam word_t HIT_ADDR      = DEFAULT_HIT_COUNT_ADDR;
   localparam int    ACC_TIMEOUT   = 100;
   localparam int    FLUSH_TIMEOUT = 2000;
   localparam int    SHADOW_WORDS  = 128;

   logic  CLK;
   logic  nRST;
   logic  dmem_ren;
   logic  dmem_wen;
   logic  halt;
   word_t dmem_addr;
   word_t dmem_store;
   word_t dmem_load;
   logic  dhit;
   logic  flushed;
   logic  mem_ren;
   logic  mem_wen;
   logic  mem_wait;
   word_t mem_addr;
   word_t mem_store;
   word_t mem_load;

   // shadow of every word the test stored
   // indexed by addr[8:2]
   word_t       shadow    [SHADOW_WORDS];
   logic        written   [SHADOW_WORDS];
   // reference tags, valid bits and lru per set
   logic        ref_valid [2][NUM_SETS];
   dcache_tag_t ref_tag   [2][NUM_SETS];
   logic        ref_lru   [NUM_SETS];

   word_t  exp_load;
   int     hits_expected;
   int     checks;
   int     errors;
   integer seed = 22;

   dcache #(
      .HIT_COUNT_ADDR (HIT_ADDR)
   ) UUT (
      .CLK        (CLK),
      .nRST       (nRST),
      .dmem_ren   (dmem_ren),
      .dmem_wen   (dmem_wen),
      .dmem_addr  (dmem_addr),
      .dmem_store (dmem_store),
      .halt       (halt),
      .dmem_load  (dmem_load),
      .dhit       (dhit),
      .flushed    (flushed),
      .mem_ren    (mem_ren),
      .mem_wen    (mem_wen),
      .mem_addr   (mem_addr),
      .mem_store  (mem_store),
      .mem_load   (mem_load),
      .mem_wait   (mem_wait)
   );

   dcache_ram_model #(
      .PATTERN (PATTERN)
   ) u_ram (
      .CLK       (CLK),
      .nRST      (nRST),
      .mem_ren   (mem_ren),
      .mem_wen   (mem_wen),
      .mem_addr  (mem_addr),
      .mem_store (mem_store),
      .mem_load  (mem_load),
      .mem_wait  (mem_wait)
   );

   initial begin
      CLK = 1'b0;
      forever #2 CLK = ~CLK;
   end

   // stored word if written, else the memory's initial word
   function automatic word_t expected_load(input word_t a);
      int i;
      i = a[8:2];
      if (written[i]) begin
         return shadow[i];
      end
      else begin
         return a ^ PATTERN;
      end
   endfunction

   // predicts hit or miss, then applies the replacement rule
   function automatic logic model_access(input word_t a);
      dcache_idx_t s;
      dcache_tag_t t;
      logic        w;
      logic        is_hit;
      s      = a[5:3];
      t      = a[31:6];
      is_hit = 1'b1;
      if (ref_valid[0][s] && ref_tag[0][s] == t) begin
         w = 1'b0;
      end
      else if (ref_valid[1][s] && ref_tag[1][s] == t) begin
         w = 1'b1;
      end
      else begin
         is_hit = 1'b0;
         // empty way first, then lru
         if (!ref_valid[0][s]) begin
            w = 1'b0;
         end
         else if (!ref_valid[1][s]) begin
            w = 1'b1;
         end
         else begin
            w = ref_lru[s];
         end
      end
      ref_valid[w][s] = 1'b1;
      ref_tag[w][s]   = t;
      ref_lru[s]      = ~w;
      return is_hit;
   endfunction

   task automatic check_value(input word_t got, input word_t exp, input string what);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("** Error at %0t: %s, got %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic abort_run(input string why);
      $display("%s at time %0t", why, $time);
      $display("RESULT: FAIL");
      $finish;
   endtask

   task automatic report_test(input int num, input string name, input int mark);
      if (errors == mark) begin
         $display("test %0d %s: passed", num, name);
      end
      else begin
         $display("test %0d %s: failed with %0d errors", num, name, errors - mark);
      end
   endtask

   // one request held until dhit then dropped for a cycle
   task automatic cpu_access(input logic is_write, input word_t a, input word_t d);
      logic exp_hit;
      int   waited;
      exp_hit  = model_access(a);
      exp_load = expected_load(a);
      @(negedge CLK);
      dmem_ren   = !is_write;
      dmem_wen   = is_write;
      dmem_addr  = a;
      dmem_store = d;
      waited     = 0;
      @(posedge CLK);
      while (!dhit && waited < ACC_TIMEOUT) begin
         waited++;
         @(posedge CLK);
      end
      if (!dhit) begin
         abort_run($sformatf("no dhit for request to %h", a));
      end
      else begin
         // a hit answers in the request cycle
         check_value(word_t'(waited == 0), word_t'(exp_hit), $sformatf("hit on %h", a));
         if (exp_hit) begin
            hits_expected++;
         end
         if (is_write) begin
            shadow[a[8:2]]  = d;
            written[a[8:2]] = 1'b1;
         end
         @(negedge CLK);
         dmem_ren = 1'b0;
         dmem_wen = 1'b0;
      end
   endtask

   // halt, wait for flushed, then inspect memory
   task automatic flush_and_check();
      int waited;
      @(negedge CLK);
      halt   = 1'b1;
      waited = 0;
      while (!flushed && waited < FLUSH_TIMEOUT) begin
         @(negedge CLK);
         waited++;
      end
      if (!flushed) begin
         abort_run("flushed never rose after halt");
      end
      else begin
         for (int i = 0; i < SHADOW_WORDS; i++) begin
            if (written[i]) begin
               check_value(u_ram.mem[i], shadow[i], $sformatf("memory word %0d", i));
            end
         end
         check_value(u_ram.mem[HIT_ADDR[13:2]], hits_expected, "hit count");
      end
   endtask

   // load compare at every read's dhit
   always @(posedge CLK) begin
      if (nRST && dhit && dmem_ren) begin
         check_value(dmem_load, exp_load, $sformatf("load from %h", dmem_addr));
      end
   end

   initial begin
      word_t rnd;
      word_t a;
      int    mark;
      int    total;
      nRST          = 1'b0;
      dmem_ren      = 1'b0;
      dmem_wen      = 1'b0;
      dmem_addr     = '0;
      dmem_store    = '0;
      halt          = 1'b0;
      exp_load      = '0;
      hits_expected = 0;
      checks        = 0;
      errors        = 0;
      for (int i = 0; i < SHADOW_WORDS; i++) begin
         written[i] = 1'b0;
      end
      for (int s = 0; s < NUM_SETS; s++) begin
         ref_valid[0][s] = 1'b0;
         ref_valid[1][s] = 1'b0;
         ref_lru[s]      = 1'b0;
      end
      repeat (5) @(negedge CLK);
      nRST = 1'b1;

      mark = errors;
      check_value(word_t'({dhit, mem_ren, mem_wen, flushed}), '0, "outputs after reset");
      cpu_access(1'b0, 32'h024, '0);
      report_test(1, "reset and first read", mark);

      mark = errors;
      cpu_access(1'b1, 32'h0A8, 32'h1234_5678);
      cpu_access(1'b0, 32'h0A8, '0);
      cpu_access(1'b0, 32'h0AC, '0);
      report_test(2, "write then read block", mark);

      // three tags in set 2
      // the third evicts the dirty 0x110 block
      mark = errors;
      cpu_access(1'b1, 32'h110, 32'hC0DE_0110);
      cpu_access(1'b1, 32'h150, 32'hC0DE_0150);
      cpu_access(1'b1, 32'h194, 32'hC0DE_0194);
      check_value(u_ram.mem[12'h044], 32'hC0DE_0110, "writeback of evicted block");
      cpu_access(1'b0, 32'h110, '0);
      cpu_access(1'b0, 32'h150, '0);
      cpu_access(1'b0, 32'h194, '0);
      report_test(3, "dirty eviction", mark);

      // 128 words over 8 tags per set
      mark = errors;
      for (int n = 0; n < 200; n++) begin
         rnd = $random(seed);
         a   = {23'd0, rnd[6:0], 2'b00};
         cpu_access(rnd[7], a, $random(seed));
      end
      report_test(4, "random accesses", mark);

      mark = errors;
      flush_and_check();
      report_test(5, "flush on halt", mark);

      total = errors + UUT.u_checker.fail_count;
      $display("checks %0d, errors %0d, assertion failures %0d",
               checks, errors, UUT.u_checker.fail_count);
      if (total == 0) begin
         $display("RESULT: PASS");
      end
      else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule
